/* logic/isaPkg.sv */
`default_nettype none

package isaPkg;

	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;

	// Primary opcodes
	localparam logic [opcodeWidth-1:0] OpR = 6'h00;
	localparam logic [opcodeWidth-1:0] OpJ = 6'h02;
	localparam logic [opcodeWidth-1:0] OpJal = 6'h03;
	localparam logic [opcodeWidth-1:0] OpBeq = 6'h04;
	localparam logic [opcodeWidth-1:0] OpBne = 6'h05;
	localparam logic [opcodeWidth-1:0] OpBle = 6'h06;
	localparam logic [opcodeWidth-1:0] OpBgt = 6'h07;
	localparam logic [opcodeWidth-1:0] OpAddi = 6'h08;
	localparam logic [opcodeWidth-1:0] OpAddiu = 6'h09;
	localparam logic [opcodeWidth-1:0] OpSlti = 6'h0a;
	localparam logic [opcodeWidth-1:0] OpLw = 6'h23;
	localparam logic [opcodeWidth-1:0] OpSw = 6'h2b;

	// Function field of R-type words
	localparam logic [functWidth-1:0] FnJr = 6'h08;
	localparam logic [functWidth-1:0] FnBreak = 6'h0d;
	localparam logic [functWidth-1:0] FnAdd = 6'h20;
	localparam logic [functWidth-1:0] FnSub = 6'h22;
	localparam logic [functWidth-1:0] FnAnd = 6'h24;
	localparam logic [functWidth-1:0] FnSlt = 6'h2a;

	typedef enum logic [3:0] {
		ClassAluReg,
		ClassAluImm,
		ClassSetLess,
		ClassBranch,
		ClassJump,
		ClassJumpReg,
		ClassJumpLink,
		ClassLoad,
		ClassStore,
		ClassHalt,
		ClassInvalid
	} instrClass_t;

	typedef enum logic [1:0] {BranchEq, BranchNe, BranchLe, BranchGt} branchKind_t;

	// Encodings as seen by the ALU
	typedef enum logic [2:0] {
		AluPass = 3'b000,
		AluAdd = 3'b001,
		AluSub = 3'b010,
		AluAnd = 3'b011,
		AluCompare = 3'b111
	} aluOp_t;

	typedef struct packed {
		instrClass_t instrClass;
		branchKind_t branchKind;
		aluOp_t aluOp;
		logic trapsOnOverflow;
		logic immediate;
		logic signExtend;
	} decodedInstr_t;

endpackage

`default_nettype wire

/* logic/controlPkg.sv */
`default_nettype none

package controlPkg;

	typedef enum logic [3:0] {
		PhaseFetch,
		PhaseFetchLatch,
		PhaseDecode,
		PhaseExecute,
		PhaseFlagWait,
		PhaseResolve,
		PhaseMemAccess,
		PhaseMemLatch,
		PhaseWriteback,
		PhaseLink,
		PhaseTrapSave,
		PhaseTrapFetch,
		PhaseTrapJump,
		PhaseHalt
	} phase_t;

	// Memory address mux
	typedef enum logic [1:0] {
		AddrPc,
		AddrAluOut,
		AddrOverflowVector,
		AddrInvalidVector
	} addrSel_t;

	typedef enum logic [1:0] {
		SrcAPc = 2'b00,
		SrcAMdr = 2'b01,
		SrcARegA = 2'b10
	} aluSrcA_t;

	typedef enum logic [2:0] {
		SrcBRegB = 3'b000,
		SrcBOne = 3'b001,
		SrcBFour = 3'b010,
		SrcBBranchOffset = 3'b011,
		SrcBImmediate = 3'b100
	} aluSrcB_t;

	typedef enum logic [1:0] {
		PcJumpTarget = 2'b00,
		PcAluResult = 2'b01,
		PcBranchTarget = 2'b11
	} pcSource_t;

	typedef enum logic [1:0] {
		DstRt = 2'b00,
		DstRd = 2'b01,
		DstReturnReg = 2'b11
	} regDst_t;

	// Less and notLess write constant one and zero
	typedef enum logic [2:0] {
		ToRegAluOut,
		ToRegMdr,
		ToRegReturnAddr,
		ToRegLess,
		ToRegNotLess
	} memToReg_t;

	typedef struct packed {
		addrSel_t memAddrSel;
		aluSrcA_t aluSrcA;
		aluSrcB_t aluSrcB;
		isaPkg::aluOp_t aluOp;
		pcSource_t pcSource;
		logic aluOrMem;
		regDst_t regDst;
		memToReg_t memToReg;
		logic signExtend;
		logic irWrite;
		logic pcWrite;
		logic regWrite;
		logic aWrite;
		logic bWrite;
		logic aluOutWrite;
		logic mdrWrite;
		logic epcWrite;
		logic writeData;
	} controlWord_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
	} wbReq_t;

	localparam controlWord_t ControlIdle = '0;

endpackage

`default_nettype wire

/* logic/instructionDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instructionDecoder
	import isaPkg::*;
(
	input logic clock,
	input logic reset,
	input logic capture,
	input logic [opcodeWidth-1:0] opcode,
	input logic [functWidth-1:0] funct,
	output decodedInstr_t decoded
);

	decodedInstr_t current;
	decodedInstr_t held;

	always_comb begin
		current = '0;
		current.instrClass = ClassInvalid;
		current.aluOp = AluAdd;
		case (opcode)
			OpR: begin
				case (funct)
					FnAdd: begin
						current.instrClass = ClassAluReg;
						current.trapsOnOverflow = 1'b1;
					end
					FnSub: begin
						current.instrClass = ClassAluReg;
						current.aluOp = AluSub;
						current.trapsOnOverflow = 1'b1;
					end
					FnAnd: begin
						current.instrClass = ClassAluReg;
						current.aluOp = AluAnd;
					end
					FnSlt: begin
						current.instrClass = ClassSetLess;
						current.aluOp = AluCompare;
					end
					FnJr: begin
						current.instrClass = ClassJumpReg;
						current.aluOp = AluPass;
					end
					FnBreak: current.instrClass = ClassHalt;
					default: current.instrClass = ClassInvalid;
				endcase
			end
			OpAddi: begin
				current.instrClass = ClassAluImm;
				current.trapsOnOverflow = 1'b1;
			end
			OpAddiu: current.instrClass = ClassAluImm;
			OpSlti: begin
				current.instrClass = ClassSetLess;
				current.aluOp = AluCompare;
			end
			OpBeq: begin
				current.instrClass = ClassBranch;
				current.aluOp = AluSub;
				current.branchKind = BranchEq;
			end
			OpBne: begin
				current.instrClass = ClassBranch;
				current.aluOp = AluSub;
				current.branchKind = BranchNe;
			end
			OpBle: begin
				current.instrClass = ClassBranch;
				current.aluOp = AluCompare;
				current.branchKind = BranchLe;
			end
			OpBgt: begin
				current.instrClass = ClassBranch;
				current.aluOp = AluCompare;
				current.branchKind = BranchGt;
			end
			OpJ: current.instrClass = ClassJump;
			OpJal: current.instrClass = ClassJumpLink;
			OpLw: current.instrClass = ClassLoad;
			OpSw: current.instrClass = ClassStore;
			default: current.instrClass = ClassInvalid;
		endcase
		// I-type words take rt and the sign-extended immediate
		current.immediate = (opcode != OpR) &&
			(current.instrClass inside {ClassAluImm, ClassSetLess, ClassLoad, ClassStore});
		current.signExtend = current.immediate;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			held <= '0;
		end else if (capture) begin
			held <= current;
		end
	end

	// The decode cycle sees the fresh result, later cycles the held one
	assign decoded = capture ? current : held;

endmodule

`default_nettype wire

/* logic/controlSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module controlSequencer
	import isaPkg::*, controlPkg::*;
#(
	parameter int aluSettleCycles = 2
) (
	input logic clock,
	input logic reset,
	input decodedInstr_t decoded,
	input logic zero,
	input logic overflow,
	input logic greater,
	input logic less,
	input logic wbAck,
	output wbReq_t wbReq,
	output logic capture,
	output phase_t nextPhase,
	output logic conditionMet
);

	localparam int countWidth = $clog2(aluSettleCycles + 1);

	phase_t phase;
	logic [countWidth-1:0] waitCount;
	logic waitDone;
	logic ackSeen;
	logic trapNow;
	logic branchTaken;
	wbReq_t nextReq;

	// Ack only counts while a request is out
	assign ackSeen = wbAck && wbReq.stb;
	assign waitDone = (waitCount == countWidth'(aluSettleCycles - 1));
	assign trapNow = decoded.trapsOnOverflow && overflow;

	always_comb begin
		case (decoded.branchKind)
			BranchEq: branchTaken = zero;
			BranchNe: branchTaken = !zero;
			BranchLe: branchTaken = !greater;
			default: branchTaken = greater;
		endcase
	end

	always_comb begin
		nextPhase = phase;
		case (phase)
			PhaseFetch: if (ackSeen) nextPhase = PhaseFetchLatch;
			PhaseFetchLatch: nextPhase = PhaseDecode;
			PhaseDecode: begin
				case (decoded.instrClass)
					ClassJumpLink: nextPhase = PhaseLink;
					ClassHalt: nextPhase = PhaseHalt;
					ClassInvalid: nextPhase = PhaseTrapSave;
					default: nextPhase = PhaseExecute;
				endcase
			end
			PhaseExecute: begin
				case (decoded.instrClass)
					ClassAluReg, ClassAluImm: begin
						nextPhase = trapNow ? PhaseTrapSave : PhaseWriteback;
					end
					ClassSetLess: nextPhase = PhaseWriteback;
					ClassBranch: nextPhase = PhaseFlagWait;
					ClassLoad, ClassStore: nextPhase = PhaseMemAccess;
					default: nextPhase = PhaseFetch;
				endcase
			end
			PhaseFlagWait: if (waitDone) nextPhase = PhaseResolve;
			PhaseResolve: nextPhase = PhaseFetch;
			PhaseMemAccess: begin
				if (ackSeen) begin
					nextPhase = (decoded.instrClass == ClassStore) ? PhaseFetch : PhaseMemLatch;
				end
			end
			PhaseMemLatch: nextPhase = PhaseWriteback;
			PhaseWriteback: nextPhase = PhaseFetch;
			PhaseLink: nextPhase = PhaseExecute;
			PhaseTrapSave: nextPhase = PhaseTrapFetch;
			PhaseTrapFetch: if (ackSeen) nextPhase = PhaseTrapJump;
			PhaseTrapJump: nextPhase = PhaseFetch;
			PhaseHalt: nextPhase = PhaseHalt;
			default: nextPhase = PhaseFetch;
		endcase
	end

	// Request follows the phase being entered
	always_comb begin
		nextReq = '0;
		if (nextPhase inside {PhaseFetch, PhaseMemAccess, PhaseTrapFetch}) begin
			nextReq.cyc = 1'b1;
			nextReq.stb = 1'b1;
		end
		nextReq.we = (nextPhase == PhaseMemAccess) && (decoded.instrClass == ClassStore);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= PhaseFetch;
			waitCount <= '0;
			wbReq <= '0;
			capture <= 1'b0;
			conditionMet <= 1'b0;
		end else begin
			phase <= nextPhase;
			wbReq <= nextReq;
			capture <= (nextPhase == PhaseDecode);
			if (phase == PhaseFlagWait && !waitDone) begin
				waitCount <= waitCount + 1'b1;
			end else begin
				waitCount <= '0;
			end
			// Branch flags are trusted only after the settle wait
			if (phase == PhaseFlagWait && waitDone) begin
				conditionMet <= branchTaken;
			end else if (phase == PhaseExecute && decoded.instrClass == ClassSetLess) begin
				conditionMet <= less;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/controlWordGen.sv */
`timescale 1ns/10ps
`default_nettype none

module controlWordGen
	import isaPkg::*, controlPkg::*;
(
	input logic clock,
	input logic reset,
	input phase_t nextPhase,
	input decodedInstr_t decoded,
	input logic conditionMet,
	output controlWord_t control
);

	controlWord_t nextWord;
	controlWord_t wordReg;
	logic resolveActive;
	logic setLessActive;
	addrSel_t trapVector;

	assign trapVector = (decoded.instrClass == ClassInvalid) ? AddrInvalidVector
		: AddrOverflowVector;

	always_comb begin
		nextWord = ControlIdle;
		// Register operands by default, phases below override
		nextWord.aluSrcA = SrcARegA;
		nextWord.aluSrcB = decoded.immediate ? SrcBImmediate : SrcBRegB;
		nextWord.aluOp = decoded.aluOp;
		nextWord.signExtend = decoded.signExtend;
		case (nextPhase)
			PhaseFetch, PhaseFetchLatch: begin
				nextWord.memAddrSel = AddrPc;
				nextWord.aluSrcA = SrcAPc;
				nextWord.aluSrcB = SrcBFour;
				nextWord.aluOp = AluAdd;
				nextWord.pcSource = PcAluResult;
				nextWord.irWrite = (nextPhase == PhaseFetchLatch);
				nextWord.pcWrite = (nextPhase == PhaseFetchLatch);
			end
			PhaseDecode: begin
				// Branch target is computed ahead of the decision
				nextWord.aluSrcA = SrcAPc;
				nextWord.aluSrcB = SrcBBranchOffset;
				nextWord.aluOp = AluAdd;
				nextWord.signExtend = 1'b1;
				nextWord.aWrite = 1'b1;
				nextWord.bWrite = 1'b1;
				nextWord.aluOutWrite = 1'b1;
			end
			PhaseExecute: begin
				case (decoded.instrClass)
					ClassJump, ClassJumpLink: begin
						nextWord.pcSource = PcJumpTarget;
						nextWord.pcWrite = 1'b1;
					end
					ClassJumpReg: begin
						nextWord.pcSource = PcAluResult;
						nextWord.pcWrite = 1'b1;
					end
					ClassBranch: nextWord.aluOutWrite = 1'b0;
					default: nextWord.aluOutWrite = 1'b1;
				endcase
			end
			PhaseResolve: begin
				nextWord.pcSource = PcBranchTarget;
				nextWord.pcWrite = 1'b1;
			end
			PhaseMemAccess: begin
				nextWord.memAddrSel = AddrAluOut;
				nextWord.writeData = (decoded.instrClass == ClassStore);
			end
			PhaseMemLatch: begin
				nextWord.memAddrSel = AddrAluOut;
				nextWord.mdrWrite = 1'b1;
			end
			PhaseWriteback: begin
				nextWord.regDst = decoded.immediate ? DstRt : DstRd;
				nextWord.memToReg = (decoded.instrClass == ClassLoad) ? ToRegMdr : ToRegAluOut;
				nextWord.regWrite = 1'b1;
			end
			PhaseLink: begin
				nextWord.regDst = DstReturnReg;
				nextWord.memToReg = ToRegReturnAddr;
				nextWord.regWrite = 1'b1;
			end
			PhaseTrapSave: begin
				// PC was already advanced, so step back one word
				nextWord.aluSrcA = SrcAPc;
				nextWord.aluSrcB = SrcBFour;
				nextWord.aluOp = AluSub;
				nextWord.epcWrite = 1'b1;
			end
			PhaseTrapFetch: nextWord.memAddrSel = trapVector;
			PhaseTrapJump: begin
				nextWord.memAddrSel = trapVector;
				nextWord.aluOrMem = 1'b1;
				nextWord.mdrWrite = 1'b1;
				nextWord.pcWrite = 1'b1;
			end
			default: nextWord = ControlIdle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wordReg <= ControlIdle;
			resolveActive <= 1'b0;
			setLessActive <= 1'b0;
		end else begin
			wordReg <= nextWord;
			resolveActive <= (nextPhase == PhaseResolve);
			setLessActive <= (nextPhase == PhaseWriteback) &&
				(decoded.instrClass == ClassSetLess);
		end
	end

	// conditionMet lands on the same edge as the word, so qualify after the register
	always_comb begin
		control = wordReg;
		if (resolveActive) begin
			control.pcWrite = conditionMet;
		end
		if (setLessActive) begin
			control.memToReg = conditionMet ? ToRegLess : ToRegNotLess;
		end
	end

endmodule

`default_nettype wire

/* logic/controlTop.sv */
`timescale 1ns/10ps
`default_nettype none

module controlTop
	import isaPkg::*, controlPkg::*;
#(
	parameter int aluSettleCycles = 2
) (
	input logic clock,
	input logic reset,
	input logic [opcodeWidth-1:0] opcode,
	input logic [functWidth-1:0] funct,
	input logic zero,
	input logic overflow,
	input logic greater,
	input logic less,
	input logic wbAck,
	output wbReq_t wbReq,
	output controlWord_t control
);

	decodedInstr_t decoded;
	logic capture;
	phase_t nextPhase;
	logic conditionMet;

	instructionDecoder u_decoder (
		.clock(clock),
		.reset(reset),
		.capture(capture),
		.opcode(opcode),
		.funct(funct),
		.decoded(decoded)
	);

	controlSequencer #(
		.aluSettleCycles(aluSettleCycles)
	) u_sequencer (
		.clock(clock),
		.reset(reset),
		.decoded(decoded),
		.zero(zero),
		.overflow(overflow),
		.greater(greater),
		.less(less),
		.wbAck(wbAck),
		.wbReq(wbReq),
		.capture(capture),
		.nextPhase(nextPhase),
		.conditionMet(conditionMet)
	);

	controlWordGen u_wordGen (
		.clock(clock),
		.reset(reset),
		.nextPhase(nextPhase),
		.decoded(decoded),
		.conditionMet(conditionMet),
		.control(control)
	);

endmodule

`default_nettype wire

/* verif/controlTb_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module controlAssert
	import controlPkg::*;
(
	input logic clock,
	input logic reset,
	input wbReq_t wbReq,
	input logic wbAck,
	input logic capture,
	input controlWord_t control
);

	// Classic cycle, request held steady until acknowledged
	assert property (@(posedge clock) disable iff (reset)
		wbReq.stb && !wbAck |=> wbReq.cyc && wbReq.stb && $stable(wbReq.we))
		else $error("Wishbone request changed before ack");

	assert property (@(posedge clock) disable iff (reset)
		wbReq.cyc |-> $onehot0({control.regWrite, control.pcWrite, control.epcWrite}))
		else $error("More than one of regWrite, pcWrite and epcWrite during a bus cycle");

	// Decode lasts a single cycle
	assert property (@(posedge clock) disable iff (reset) capture |=> !capture)
		else $error("capture was high for more than one cycle");

endmodule

bind controlTop controlAssert u_assert (
	.clock(clock),
	.reset(reset),
	.wbReq(wbReq),
	.wbAck(wbAck),
	.capture(capture),
	.control(control)
);

`default_nettype wire

/* verif/controlTb.sv */
`timescale 1ns/10ps
`default_nettype none

module controlTb
	import isaPkg::*, controlPkg::*;
();

	localparam int aluSettleCycles = 2;
	// Roughly 40 instructions of at most 25 cycles each and doubled for margin
	localparam int maxInstrs = 40;
	localparam int maxInstrCycles = 25;
	localparam int watchdogCycles = 2 * maxInstrs * maxInstrCycles;

	logic clock = 1'b0;
	logic reset;
	logic [opcodeWidth-1:0] opcode;
	logic [functWidth-1:0] funct;
	logic zero;
	logic overflow;
	logic greater;
	logic less;
	logic wbAck = 1'b0;
	wbReq_t wbReq;
	controlWord_t control;

	int errorCount = 0;
	int checkCount = 0;
	int ackWait = -1;

	// Trace of one instruction with cycle offsets counted from its decode cycle
	int irCount, fetchPcCount, pcCount, regCount, epcCount, mdrCount;
	int pcAt, regAt, epcAt, mdrAt, busAt;
	int busCycles;
	int weCycles;
	logic writeDataSeen;
	pcSource_t pcSrcSeen;
	logic aluOrMemSeen;
	regDst_t regDstSeen;
	memToReg_t toRegSeen;
	aluOp_t aluOpSeen;
	addrSel_t busAddrSeen;

	controlTop #(
		.aluSettleCycles(aluSettleCycles)
	) u_dut (
		.clock(clock),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.zero(zero),
		.overflow(overflow),
		.greater(greater),
		.less(less),
		.wbAck(wbAck),
		.wbReq(wbReq),
		.control(control)
	);

	always #5 clock = ~clock;

	// Wishbone slave acking each request after 0 to 3 wait cycles
	always @(posedge clock) begin
		#1;
		if (reset || wbAck) begin
			wbAck = 1'b0;
			ackWait = -1;
		end else if (wbReq.stb) begin
			if (ackWait < 0) begin
				ackWait = int'($urandom % 4);
			end
			if (ackWait == 0) begin
				wbAck = 1'b1;
			end
			ackWait = ackWait - 1;
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clock);
		$display("Timeout after %0d cycles, the control unit stopped making progress",
			watchdogCycles);
		$display("tests failed");
		$finish;
	end

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	task automatic checkEqual(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		assert (got === expected) else begin
			errorCount++;
			$display("Fail %s expected %h got %h", name, expected, got);
		end
	endtask

	task automatic expectTrue(input logic condition, input string what);
		checkCount++;
		assert (condition) else begin
			errorCount++;
			$display("%s", what);
		end
	endtask

	function automatic logic anyWrite(input controlWord_t c);
		return c.irWrite | c.pcWrite | c.regWrite | c.aWrite | c.bWrite | c.aluOutWrite
			| c.mdrWrite | c.epcWrite;
	endfunction

	// Runs one instruction from fetch until the next fetch request
	task automatic runInstruction(input logic [opcodeWidth-1:0] op,
		input logic [functWidth-1:0] fn);
		bit seenDecode;
		bit done;
		int n;
		int decodeAt;
		seenDecode = 1'b0;
		done = 1'b0;
		n = 0;
		decodeAt = 0;
		opcode = op;
		funct = fn;
		irCount = 0;
		fetchPcCount = 0;
		pcCount = 0;
		regCount = 0;
		epcCount = 0;
		mdrCount = 0;
		busCycles = 0;
		weCycles = 0;
		writeDataSeen = 1'b0;
		pcAt = -1;
		regAt = -1;
		epcAt = -1;
		mdrAt = -1;
		busAt = -1;
		while (!done) begin
			step();
			n++;
			if (seenDecode && wbReq.cyc && control.memAddrSel == AddrPc) begin
				done = 1'b1;
			end else begin
				if (control.aWrite) begin
					seenDecode = 1'b1;
					decodeAt = n;
					// Branch target is PC plus offset
					checkEqual("control.aluSrcA", 32'(control.aluSrcA), 32'(SrcAPc));
					checkEqual("control.aluSrcB", 32'(control.aluSrcB),
						32'(SrcBBranchOffset));
					checkEqual("control.bWrite", 32'(control.bWrite), 32'd1);
					checkEqual("control.aluOutWrite", 32'(control.aluOutWrite), 32'd1);
				end
				if (wbReq.cyc) begin
					expectTrue(!anyWrite(control), "A register write strobe was high during a bus cycle");
					if (!seenDecode) begin
						checkEqual("control.memAddrSel", 32'(control.memAddrSel), 32'(AddrPc));
						checkEqual("wbReq.we", 32'(wbReq.we), 32'd0);
					end else begin
						busCycles++;
						if (wbReq.we) begin
							weCycles++;
						end
						busAddrSeen = control.memAddrSel;
						if (busAt < 0) begin
							busAt = n - decodeAt;
						end
					end
				end
				writeDataSeen |= control.writeData;
				if (control.irWrite) begin
					irCount++;
					if (control.pcWrite) begin
						fetchPcCount++;
					end
				end else if (control.pcWrite) begin
					pcCount++;
					pcAt = n - decodeAt;
					pcSrcSeen = control.pcSource;
					aluOrMemSeen = control.aluOrMem;
				end
				if (control.regWrite) begin
					regCount++;
					regAt = n - decodeAt;
					regDstSeen = control.regDst;
					toRegSeen = control.memToReg;
					aluOpSeen = control.aluOp;
				end
				if (control.epcWrite) begin
					epcCount++;
					epcAt = n - decodeAt;
					// EPC gets PC minus 4
					checkEqual("control.aluSrcA", 32'(control.aluSrcA), 32'(SrcAPc));
					checkEqual("control.aluSrcB", 32'(control.aluSrcB), 32'(SrcBFour));
					checkEqual("control.aluOp", 32'(control.aluOp), 32'(AluSub));
				end
				if (control.mdrWrite) begin
					mdrCount++;
					mdrAt = n - decodeAt;
				end
			end
		end
		checkEqual("irWrite count", irCount, 32'd1);
		checkEqual("fetch pcWrite count", fetchPcCount, 32'd1);
	endtask

	task automatic resetAndFetch();
		reset = 1'b1;
		repeat (8) begin
			step();
			expectTrue(!anyWrite(control) && !control.writeData, "A write strobe was high in reset");
			expectTrue(!wbReq.cyc && !wbReq.stb, "The bus was requested during reset");
		end
		reset = 1'b0;
		step();
		expectTrue(wbReq.cyc && wbReq.stb, "Fetch did not start in the first cycle after reset");
	endtask

	task automatic aluWriteback(input logic [opcodeWidth-1:0] op,
		input logic [functWidth-1:0] fn, input logic lessIn, input logic overflowIn,
		input aluOp_t expOp, input regDst_t expDst, input memToReg_t expToReg);
		less = lessIn;
		overflow = overflowIn;
		runInstruction(op, fn);
		checkEqual("regWrite count", regCount, 32'd1);
		checkEqual("epcWrite count", epcCount, 32'd0);
		checkEqual("control.aluOp", 32'(aluOpSeen), 32'(expOp));
		checkEqual("control.regDst", 32'(regDstSeen), 32'(expDst));
		checkEqual("control.memToReg", 32'(toRegSeen), 32'(expToReg));
		less = 1'b0;
		overflow = 1'b0;
	endtask

	task automatic trapSequence(input logic [opcodeWidth-1:0] op,
		input logic [functWidth-1:0] fn, input addrSel_t expVector);
		overflow = 1'b1;
		runInstruction(op, fn);
		overflow = 1'b0;
		checkEqual("regWrite count", regCount, 32'd0);
		checkEqual("epcWrite count", epcCount, 32'd1);
		checkEqual("control.memAddrSel", 32'(busAddrSeen), 32'(expVector));
		checkEqual("pcWrite count", pcCount, 32'd1);
		checkEqual("control.aluOrMem", 32'(aluOrMemSeen), 32'd1);
		expectTrue(epcAt < busAt && busAt < pcAt, "Trap steps came out of order");
	endtask

	task automatic branchDecision(input logic [opcodeWidth-1:0] op);
		logic taken;
		repeat (4) begin
			zero = 1'($urandom % 2);
			greater = 1'($urandom % 2);
			case (op)
				OpBeq: taken = zero;
				OpBne: taken = !zero;
				OpBle: taken = !greater;
				default: taken = greater;
			endcase
			runInstruction(op, '0);
			checkEqual("pcWrite count", pcCount, 32'(taken));
			checkEqual("regWrite count", regCount, 32'd0);
			if (taken) begin
				checkEqual("control.pcSource", 32'(pcSrcSeen), 32'(PcBranchTarget));
				checkEqual("pcWrite cycle after decode", pcAt, aluSettleCycles + 2);
			end
		end
	endtask

	task automatic loadStore();
		runInstruction(OpLw, '0);
		checkEqual("control.memAddrSel", 32'(busAddrSeen), 32'(AddrAluOut));
		checkEqual("wbReq.we cycles", weCycles, 32'd0);
		checkEqual("mdrWrite count", mdrCount, 32'd1);
		checkEqual("regWrite count", regCount, 32'd1);
		checkEqual("control.memToReg", 32'(toRegSeen), 32'(ToRegMdr));
		expectTrue(busAt < mdrAt && mdrAt < regAt, "Load steps came out of order");
		runInstruction(OpSw, '0);
		checkEqual("control.memAddrSel", 32'(busAddrSeen), 32'(AddrAluOut));
		expectTrue(busCycles > 0 && weCycles == busCycles, "Store did not hold we high");
		checkEqual("control.writeData", 32'(writeDataSeen), 32'd1);
		checkEqual("regWrite count", regCount, 32'd0);
	endtask

	task automatic jumps();
		runInstruction(OpJ, '0);
		checkEqual("pcWrite count", pcCount, 32'd1);
		checkEqual("control.pcSource", 32'(pcSrcSeen), 32'(PcJumpTarget));
		checkEqual("regWrite count", regCount, 32'd0);
		runInstruction(OpR, FnJr);
		checkEqual("pcWrite count", pcCount, 32'd1);
		checkEqual("control.pcSource", 32'(pcSrcSeen), 32'(PcAluResult));
		runInstruction(OpJal, '0);
		checkEqual("pcWrite count", pcCount, 32'd1);
		checkEqual("regWrite count", regCount, 32'd1);
		checkEqual("control.regDst", 32'(regDstSeen), 32'(DstReturnReg));
		checkEqual("control.memToReg", 32'(toRegSeen), 32'(ToRegReturnAddr));
		checkEqual("control.pcSource", 32'(pcSrcSeen), 32'(PcJumpTarget));
		expectTrue(regAt >= 0 && regAt < pcAt, "jal wrote the PC before the return register");
	endtask

	task automatic breakHalts();
		opcode = OpR;
		funct = FnBreak;
		while (!control.aWrite) begin
			step();
		end
		repeat (50) begin
			step();
			expectTrue(!wbReq.cyc, "A bus cycle started after break");
		end
	endtask

	initial begin
		void'($urandom(32'had12));
		reset = 1'b1;
		opcode = OpR;
		funct = FnAdd;
		zero = 1'b0;
		overflow = 1'b0;
		greater = 1'b0;
		less = 1'b0;
		resetAndFetch();
		aluWriteback(OpR, FnAdd, 1'b0, 1'b0, AluAdd, DstRd, ToRegAluOut);
		aluWriteback(OpR, FnSub, 1'b0, 1'b0, AluSub, DstRd, ToRegAluOut);
		aluWriteback(OpR, FnAnd, 1'b0, 1'b0, AluAnd, DstRd, ToRegAluOut);
		aluWriteback(OpR, FnSlt, 1'b1, 1'b0, AluCompare, DstRd, ToRegLess);
		aluWriteback(OpR, FnSlt, 1'b0, 1'b0, AluCompare, DstRd, ToRegNotLess);
		aluWriteback(OpAddi, '0, 1'b0, 1'b0, AluAdd, DstRt, ToRegAluOut);
		aluWriteback(OpAddiu, '0, 1'b0, 1'b0, AluAdd, DstRt, ToRegAluOut);
		aluWriteback(OpAddiu, '0, 1'b0, 1'b1, AluAdd, DstRt, ToRegAluOut);
		aluWriteback(OpSlti, '0, 1'b1, 1'b0, AluCompare, DstRt, ToRegLess);
		aluWriteback(OpSlti, '0, 1'b0, 1'b0, AluCompare, DstRt, ToRegNotLess);
		trapSequence(OpR, FnAdd, AddrOverflowVector);
		trapSequence(OpR, FnSub, AddrOverflowVector);
		trapSequence(OpAddi, '0, AddrOverflowVector);
		trapSequence(6'h3f, '0, AddrInvalidVector);
		branchDecision(OpBeq);
		branchDecision(OpBne);
		branchDecision(OpBle);
		branchDecision(OpBgt);
		loadStore();
		jumps();
		breakHalts();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
logic/isaPkg.sv
logic/controlPkg.sv
logic/instructionDecoder.sv
logic/controlSequencer.sv
logic/controlWordGen.sv
logic/controlTop.sv
verif/controlTb_assert.sv
verif/controlTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= controlTb
FILELIST ?= flist.f
OBJDIR ?= obj_dir
PASS_TEXT = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
